/* na_pkg.sv */
/*
 * Network adapter package
 * Widths, bus address map, packet field positions and tile identity
 */
package na_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int FLIT_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int ADDR_WIDTH = 32;

  // Region field sits in address bits 23:20
  localparam int REGION_LSB   = 20;
  localparam int REGION_WIDTH = 4;

  // Flit buffers on the network side
  localparam int BUF_DEPTH = 4;

  // Capacity of each message store, also the largest packet
  localparam int MSG_SIZE = 16;

  ////////////////////////////////////////
  // Packet header fields
  ////////////////////////////////////////

  localparam int              CLASS_LSB   = 24;
  localparam int              CLASS_WIDTH = 3;
  localparam logic [2:0]      CLASS_MSG   = 3'd1;

  // Tile identity
  localparam logic [DATA_WIDTH-1:0] TILE_ID    = 32'd5;
  localparam logic [DATA_WIDTH-1:0] CORE_BASE  = 32'd8;
  localparam logic [DATA_WIDTH-1:0] NA_VERSION = 32'd1;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  typedef enum logic [REGION_WIDTH-1:0] {
    REGION_CONF = 4'h0,
    REGION_MSG  = 4'h1
  } region_e;

  // Word offsets inside the configuration region
  typedef enum logic [5:0] {
    CONF_TILE_ID   = 6'h00,
    CONF_CORE_BASE = 6'h04,
    CONF_VERSION   = 6'h08
  } conf_reg_e;

endpackage

/* noc_buffer.sv */
/*
 * Flit FIFO with valid/ready handshake on both sides
 * Keeps packet order and the last marker under back-pressure
 */
module noc_buffer
  import na_pkg::*;
#(
  parameter int DEPTH = BUF_DEPTH
) (
  input  logic                  clk,
  input  logic                  rst_i,

  input  logic [FLIT_WIDTH-1:0] in_flit_i,
  input  logic                  in_last_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,

  output logic [FLIT_WIDTH-1:0] out_flit_o,
  output logic                  out_last_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [FLIT_WIDTH-1:0] flit_mem [DEPTH];
  logic [DEPTH-1:0]      last_mem;
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      fill;
  logic [CNT_W-1:0]      fill_next;
  logic                  ready_q;
  logic                  valid_q;
  logic                  push;
  logic                  pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push = in_valid_i & ready_q;
  assign pop  = valid_q & out_ready_i;

  always_comb begin
    fill_next = fill;
    if (push && !pop) begin
      fill_next = fill + 1'b1;
    end else if (pop && !push) begin
      fill_next = fill - 1'b1;
    end
  end

  // Ready and valid come straight from flops
  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      fill    <= '0;
      ready_q <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      fill    <= fill_next;
      ready_q <= (fill_next != CNT_W'(DEPTH));
      valid_q <= (fill_next != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      flit_mem[wr_ptr] <= in_flit_i;
      last_mem[wr_ptr] <= in_last_i;
    end
  end

  assign in_ready_o  = ready_q;
  assign out_valid_o = valid_q;
  assign out_flit_o  = flit_mem[rd_ptr];
  assign out_last_o  = last_mem[rd_ptr];

endmodule

/* na_wb_decode.sv */
/*
 * Bus slave region decode
 * Steers the strobe to one region and returns its ack and read data,
 * unknown regions get an error
 */
module na_wb_decode
  import na_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_i,

  input  logic [ADDR_WIDTH-1:0] wbs_adr_i,
  input  logic                  wbs_cyc_i,
  input  logic                  wbs_stb_i,
  output logic [DATA_WIDTH-1:0] wbs_dat_o,
  output logic                  wbs_ack_o,
  output logic                  wbs_err_o,

  output logic                  conf_stb_o,
  output logic                  msg_stb_o,
  input  logic [DATA_WIDTH-1:0] conf_dat_i,
  input  logic                  conf_ack_i,
  input  logic [DATA_WIDTH-1:0] msg_dat_i,
  input  logic                  msg_ack_i
);

  logic [REGION_WIDTH-1:0] region;
  logic                    req;
  logic                    sel_conf;
  logic                    sel_msg;
  logic                    err_q;

  assign region   = wbs_adr_i[REGION_LSB +: REGION_WIDTH];
  assign req      = wbs_cyc_i & wbs_stb_i;
  assign sel_conf = (region == REGION_CONF);
  assign sel_msg  = (region == REGION_MSG);

  assign conf_stb_o = req & sel_conf;
  assign msg_stb_o  = req & sel_msg;

  // Error pulse one cycle after strobe, nobody else answers here
  always_ff @(posedge clk) begin
    if (rst_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req & ~sel_conf & ~sel_msg & ~err_q;
    end
  end

  assign wbs_err_o = err_q;

  // Response path from the selected region
  always_comb begin
    wbs_dat_o = '0;
    wbs_ack_o = 1'b0;
    if (sel_conf) begin
      wbs_dat_o = conf_dat_i;
      wbs_ack_o = conf_ack_i;
    end else if (sel_msg) begin
      wbs_dat_o = msg_dat_i;
      wbs_ack_o = msg_ack_i;
    end
  end

endmodule

/* na_conf.sv */
/*
 * Configuration register bank
 * Read-only tile identity words, writes are acknowledged and dropped
 */
module na_conf
  import na_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_i,

  input  logic [5:0]            adr_i,
  input  logic                  stb_i,
  output logic [DATA_WIDTH-1:0] dat_o,
  output logic                  ack_o
);

  logic                  ack_q;
  logic [DATA_WIDTH-1:0] dat_q;
  logic [DATA_WIDTH-1:0] rd_word;

  // Offset lookup
  always_comb begin
    case (adr_i)
      CONF_TILE_ID:   rd_word = TILE_ID;
      CONF_CORE_BASE: rd_word = CORE_BASE;
      CONF_VERSION:   rd_word = NA_VERSION;
      default:        rd_word = '0;
    endcase
  end

  // One-cycle ack, master drops strobe right after
  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= stb_i & ~ack_q;
    end
  end

  always_ff @(posedge clk) begin
    if (stb_i && !ack_q) begin
      dat_q <= rd_word;
    end
  end

  assign ack_o = ack_q;
  assign dat_o = dat_q;

endmodule

/* mp_simple_rx.sv */
/*
 * Message receive path
 * Stores complete message packets, drops other classes and raises an
 * interrupt while a packet waits; software reads the size, then the flits
 */
module mp_simple_rx
  import na_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_i,

  input  logic [FLIT_WIDTH-1:0] in_flit_i,
  input  logic                  in_last_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,

  input  logic                  stb_i,
  input  logic                  we_i,
  output logic [DATA_WIDTH-1:0] dat_o,
  output logic                  ack_o,
  output logic                  irq_o
);

  localparam int SIZE_W = $clog2(MSG_SIZE + 1);
  localparam int QPTR_W = $clog2(MSG_SIZE);

  typedef enum logic {IDLE_SIZE, DATA} rx_state_e;

  rx_state_e             state;
  logic [SIZE_W-1:0]     size_q [MSG_SIZE];
  logic [QPTR_W-1:0]     sz_wr;
  logic [QPTR_W-1:0]     sz_rd;
  logic [SIZE_W-1:0]     pkt_cnt;
  logic [SIZE_W-1:0]     cur_len;
  logic                  at_head;
  logic                  drop_q;
  logic                  drop_now;
  logic                  accept;
  logic                  keep;
  logic                  store_ready;
  logic [FLIT_WIDTH-1:0] store_flit;
  logic                  store_last;
  logic                  store_valid;
  logic                  rd_req;
  logic                  size_rd;
  logic                  data_rd;
  logic                  pkt_push;
  logic                  pkt_pop;
  logic                  ack_q;
  logic [DATA_WIDTH-1:0] dat_q;

  ////////////////////////////////////////
  // Network side and class filter
  ////////////////////////////////////////

  assign accept   = in_valid_i & in_ready_o;
  assign drop_now = drop_q |
                    (at_head & (in_flit_i[CLASS_LSB +: CLASS_WIDTH] != CLASS_MSG));
  assign keep     = accept & ~drop_now;
  assign pkt_push = keep & in_last_i;

  // A packet being dropped never waits for store space
  assign in_ready_o = drop_q | store_ready;

  noc_buffer #(
    .DEPTH (MSG_SIZE)
  ) u_store (
    .clk         (clk),
    .rst_i       (rst_i),
    .in_flit_i   (in_flit_i),
    .in_last_i   (in_last_i),
    .in_valid_i  (in_valid_i & ~drop_now),
    .in_ready_o  (store_ready),
    .out_flit_o  (store_flit),
    .out_last_o  (store_last),
    .out_valid_o (store_valid),
    .out_ready_i (data_rd)
  );

  ////////////////////////////////////////
  // Bus read side
  ////////////////////////////////////////

  assign rd_req  = stb_i & ~we_i & ~ack_q;
  assign size_rd = rd_req & (state == IDLE_SIZE);
  assign data_rd = rd_req & (state == DATA) & store_valid;
  assign pkt_pop = data_rd & store_last;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state   <= IDLE_SIZE;
      at_head <= 1'b1;
      drop_q  <= 1'b0;
      cur_len <= '0;
      pkt_cnt <= '0;
      sz_wr   <= '0;
      sz_rd   <= '0;
      ack_q   <= 1'b0;
    end else begin
      if (accept) begin
        at_head <= in_last_i;
        drop_q  <= drop_now & ~in_last_i;
      end
      if (keep) begin
        cur_len <= in_last_i ? '0 : cur_len + 1'b1;
      end
      if (pkt_push) begin
        sz_wr <= sz_wr + 1'b1;
      end
      if (pkt_pop) begin
        sz_rd <= sz_rd + 1'b1;
      end
      if (pkt_push && !pkt_pop) begin
        pkt_cnt <= pkt_cnt + 1'b1;
      end else if (pkt_pop && !pkt_push) begin
        pkt_cnt <= pkt_cnt - 1'b1;
      end
      ack_q <= size_rd | data_rd;
      // Size read with nothing stored keeps the FSM idle
      if (size_rd && pkt_cnt != '0) begin
        state <= DATA;
      end else if (pkt_pop) begin
        state <= IDLE_SIZE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pkt_push) begin
      size_q[sz_wr] <= cur_len + 1'b1;
    end
    if (size_rd) begin
      dat_q <= (pkt_cnt != '0) ? DATA_WIDTH'(size_q[sz_rd]) : '0;
    end else if (data_rd) begin
      dat_q <= store_flit;
    end
  end

  assign dat_o = dat_q;
  assign ack_o = ack_q;
  assign irq_o = (pkt_cnt != '0);

endmodule

/* mp_simple_tx.sv */
/*
 * Message send path
 * Takes a size word and then that many flit words from the bus and
 * releases them to the network with last on the final flit
 */
module mp_simple_tx
  import na_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_i,

  input  logic                  stb_i,
  input  logic                  we_i,
  input  logic [DATA_WIDTH-1:0] dat_i,
  output logic                  ack_o,

  output logic [FLIT_WIDTH-1:0] out_flit_o,
  output logic                  out_last_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i
);

  localparam int SIZE_W = $clog2(MSG_SIZE + 1);

  typedef enum logic {WAIT_SIZE, FILL} tx_state_e;

  tx_state_e         state;
  logic [SIZE_W-1:0] remain;
  logic              ack_q;
  logic              wr_req;
  logic              size_ok;
  logic              flit_ok;
  logic              stage_ready;

  assign wr_req = stb_i & we_i & ~ack_q;

  // New size only once the previous packet has fully drained
  assign size_ok = wr_req & (state == WAIT_SIZE) & ~out_valid_o;
  assign flit_ok = wr_req & (state == FILL) & stage_ready;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state  <= WAIT_SIZE;
      remain <= '0;
      ack_q  <= 1'b0;
    end else begin
      ack_q <= size_ok | flit_ok;
      if (size_ok) begin
        remain <= dat_i[SIZE_W-1:0];
        if (dat_i[SIZE_W-1:0] != '0) begin
          state <= FILL;
        end
      end else if (flit_ok) begin
        remain <= remain - 1'b1;
        if (remain == SIZE_W'(1)) begin
          state <= WAIT_SIZE;
        end
      end
    end
  end

  assign ack_o = ack_q;

  ////////////////////////////////////////
  // Staging FIFO toward the out buffer
  ////////////////////////////////////////

  noc_buffer #(
    .DEPTH (MSG_SIZE)
  ) u_staging (
    .clk         (clk),
    .rst_i       (rst_i),
    .in_flit_i   (dat_i[FLIT_WIDTH-1:0]),
    .in_last_i   (remain == SIZE_W'(1)),
    .in_valid_i  (flit_ok),
    .in_ready_o  (stage_ready),
    .out_flit_o  (out_flit_o),
    .out_last_o  (out_last_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i)
  );

endmodule

/* network_adapter.sv */
/*
 * Network adapter for one compute tile
 * Bus slave with configuration and message regions, flit buffers on
 * the network side
 */
module network_adapter
  import na_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_i,

  input  logic [FLIT_WIDTH-1:0] noc_in_flit_i,
  input  logic                  noc_in_last_i,
  input  logic                  noc_in_valid_i,
  output logic                  noc_in_ready_o,

  output logic [FLIT_WIDTH-1:0] noc_out_flit_o,
  output logic                  noc_out_last_o,
  output logic                  noc_out_valid_o,
  input  logic                  noc_out_ready_i,

  input  logic [ADDR_WIDTH-1:0] wbs_adr_i,
  input  logic [DATA_WIDTH-1:0] wbs_dat_i,
  input  logic                  wbs_cyc_i,
  input  logic                  wbs_stb_i,
  input  logic                  wbs_we_i,
  output logic [DATA_WIDTH-1:0] wbs_dat_o,
  output logic                  wbs_ack_o,
  output logic                  wbs_err_o,

  output logic                  irq_o
);

  logic [FLIT_WIDTH-1:0] rx_flit;
  logic                  rx_last;
  logic                  rx_valid;
  logic                  rx_ready;
  logic [FLIT_WIDTH-1:0] tx_flit;
  logic                  tx_last;
  logic                  tx_valid;
  logic                  tx_ready;

  logic                  conf_stb;
  logic [DATA_WIDTH-1:0] conf_dat;
  logic                  conf_ack;
  logic                  msg_stb;
  logic [DATA_WIDTH-1:0] rx_dat;
  logic                  rx_ack;
  logic                  tx_ack;

  ////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////

  // rx answers reads and tx answers writes, never both
  na_wb_decode u_decode (
    .clk        (clk),
    .rst_i      (rst_i),
    .wbs_adr_i  (wbs_adr_i),
    .wbs_cyc_i  (wbs_cyc_i),
    .wbs_stb_i  (wbs_stb_i),
    .wbs_dat_o  (wbs_dat_o),
    .wbs_ack_o  (wbs_ack_o),
    .wbs_err_o  (wbs_err_o),
    .conf_stb_o (conf_stb),
    .msg_stb_o  (msg_stb),
    .conf_dat_i (conf_dat),
    .conf_ack_i (conf_ack),
    .msg_dat_i  (rx_dat),
    .msg_ack_i  (rx_ack | tx_ack)
  );

  na_conf u_conf (
    .clk   (clk),
    .rst_i (rst_i),
    .adr_i (wbs_adr_i[5:0]),
    .stb_i (conf_stb),
    .dat_o (conf_dat),
    .ack_o (conf_ack)
  );

  mp_simple_rx u_rx (
    .clk        (clk),
    .rst_i      (rst_i),
    .in_flit_i  (rx_flit),
    .in_last_i  (rx_last),
    .in_valid_i (rx_valid),
    .in_ready_o (rx_ready),
    .stb_i      (msg_stb),
    .we_i       (wbs_we_i),
    .dat_o      (rx_dat),
    .ack_o      (rx_ack),
    .irq_o      (irq_o)
  );

  mp_simple_tx u_tx (
    .clk         (clk),
    .rst_i       (rst_i),
    .stb_i       (msg_stb),
    .we_i        (wbs_we_i),
    .dat_i       (wbs_dat_i),
    .ack_o       (tx_ack),
    .out_flit_o  (tx_flit),
    .out_last_o  (tx_last),
    .out_valid_o (tx_valid),
    .out_ready_i (tx_ready)
  );

  ////////////////////////////////////////
  // Network side
  ////////////////////////////////////////

  noc_buffer u_inbuffer (
    .clk         (clk),
    .rst_i       (rst_i),
    .in_flit_i   (noc_in_flit_i),
    .in_last_i   (noc_in_last_i),
    .in_valid_i  (noc_in_valid_i),
    .in_ready_o  (noc_in_ready_o),
    .out_flit_o  (rx_flit),
    .out_last_o  (rx_last),
    .out_valid_o (rx_valid),
    .out_ready_i (rx_ready)
  );

  noc_buffer u_outbuffer (
    .clk         (clk),
    .rst_i       (rst_i),
    .in_flit_i   (tx_flit),
    .in_last_i   (tx_last),
    .in_valid_i  (tx_valid),
    .in_ready_o  (tx_ready),
    .out_flit_o  (noc_out_flit_o),
    .out_last_o  (noc_out_last_o),
    .out_valid_o (noc_out_valid_o),
    .out_ready_i (noc_out_ready_i)
  );

endmodule

/* network_adapter_asserts.sv */
/*
 * Handshake assertions for the network adapter
 * Bus response rules and output flit hold under back-pressure
 */
module network_adapter_asserts
  import na_pkg::*;
(
  input logic                  clk,
  input logic                  rst_i,
  input logic                  wbs_ack_o,
  input logic                  wbs_err_o,
  input logic [FLIT_WIDTH-1:0] noc_out_flit_o,
  input logic                  noc_out_last_o,
  input logic                  noc_out_valid_o,
  input logic                  noc_out_ready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  a_ack_err_excl: assert property (@(posedge clk) disable iff (rst_i)
    !(wbs_ack_o && wbs_err_o))
    else $error("ack and err asserted together");

  // Stalled flit holds its data
  a_out_hold: assert property (@(posedge clk) disable iff (rst_i)
    (noc_out_valid_o && !noc_out_ready_i) |=>
      (noc_out_valid_o && $stable(noc_out_flit_o) && $stable(noc_out_last_o)))
    else $error("output flit changed while stalled");

  a_ack_pulse: assert property (@(posedge clk) disable iff (rst_i)
    wbs_ack_o |=> !wbs_ack_o)
    else $error("ack held longer than one cycle");

endmodule

bind network_adapter network_adapter_asserts u_asserts (
  .clk             (clk),
  .rst_i           (rst_i),
  .wbs_ack_o       (wbs_ack_o),
  .wbs_err_o       (wbs_err_o),
  .noc_out_flit_o  (noc_out_flit_o),
  .noc_out_last_o  (noc_out_last_o),
  .noc_out_valid_o (noc_out_valid_o),
  .noc_out_ready_i (noc_out_ready_i)
);

/* network_adapter_tb.sv */
/*
 * Testbench for the network adapter
 * Table-driven bus and network traffic, expected data computed here
 */
module network_adapter_tb
  import na_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] SEED      = 32'hbdb3_72b8;
  localparam int          TIMEOUT   = 2000;
  localparam int          MAX_FLITS = 64;

  typedef enum logic [1:0] {
    OP_BUS_READ,
    OP_BUS_WRITE,
    OP_NET_SEND,
    OP_NET_EXPECT
  } op_e;

  // Operation, address or class, flit count, expected word
  typedef struct packed {
    op_e         op;
    logic [31:0] arg;
    int          size;
    logic [31:0] expected;
  } step_t;

  localparam int NSTEPS = 14;
  localparam step_t STEPS [NSTEPS] = '{
    '{OP_BUS_READ,   32'h0000_0000,   0,  TILE_ID},
    '{OP_BUS_READ,   32'h0000_0004,   0,  CORE_BASE},
    '{OP_BUS_READ,   32'h0000_0008,   0,  NA_VERSION},
    '{OP_BUS_READ,   32'h0030_0000,   0,  32'h0},
    '{OP_BUS_WRITE,  32'h0010_0000,   5,  32'h0},
    '{OP_BUS_WRITE,  32'h0010_0000,   12, 32'h0},
    '{OP_NET_EXPECT, 32'h0,           0,  32'h0},
    '{OP_NET_SEND,   32'(CLASS_MSG),  6,  32'h0},
    '{OP_BUS_READ,   32'h0010_0000,   6,  32'd6},
    '{OP_BUS_READ,   32'h0010_0000,   0,  32'h0},
    '{OP_NET_SEND,   32'd3,           4,  32'h0},
    '{OP_NET_SEND,   32'(CLASS_MSG),  3,  32'h0},
    '{OP_BUS_READ,   32'h0010_0000,   3,  32'd3},
    '{OP_BUS_READ,   32'h0010_0000,   0,  32'h0}
  };

  logic                  clk;
  logic                  rst_i;
  logic [FLIT_WIDTH-1:0] noc_in_flit_i;
  logic                  noc_in_last_i;
  logic                  noc_in_valid_i;
  logic                  noc_in_ready_o;
  logic [FLIT_WIDTH-1:0] noc_out_flit_o;
  logic                  noc_out_last_o;
  logic                  noc_out_valid_o;
  logic                  noc_out_ready_i;
  logic [ADDR_WIDTH-1:0] wbs_adr_i;
  logic [DATA_WIDTH-1:0] wbs_dat_i;
  logic                  wbs_cyc_i;
  logic                  wbs_stb_i;
  logic                  wbs_we_i;
  logic [DATA_WIDTH-1:0] wbs_dat_o;
  logic                  wbs_ack_o;
  logic                  wbs_err_o;
  logic                  irq_o;

  logic [31:0] pay_state   = SEED;
  logic [31:0] ready_state = SEED;
  logic [31:0] tx_exp_flit [MAX_FLITS];
  logic        tx_exp_last [MAX_FLITS];
  logic [31:0] out_flit    [MAX_FLITS];
  logic        out_last    [MAX_FLITS];
  logic [31:0] rx_exp      [MAX_FLITS];
  int          tx_wr   = 0;
  int          tx_chk  = 0;
  int          rcv_cnt = 0;
  int          rx_wr   = 0;
  int          rx_rd   = 0;

  network_adapter u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s is %h, expected %h", name, got, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout: no %s within %0d cycles", what, TIMEOUT);
    $display("tests failed");
    $fatal(1);
  endtask

  // Called on a rising edge, returns on a rising edge
  task automatic bus_access(input logic we, input logic [31:0] adr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int t;
    wbs_adr_i <= adr;
    wbs_dat_i <= wdata;
    wbs_we_i  <= we;
    wbs_cyc_i <= 1'b1;
    wbs_stb_i <= 1'b1;
    t = 0;
    @(negedge clk);
    while (!wbs_ack_o && !wbs_err_o) begin
      if (t == TIMEOUT) begin
        timeout_fail("ack or err on the bus");
      end
      t++;
      @(negedge clk);
    end
    rdata = wbs_dat_o;
    err   = wbs_err_o;
    @(posedge clk);
    wbs_cyc_i <= 1'b0;
    wbs_stb_i <= 1'b0;
    wbs_we_i  <= 1'b0;
    @(posedge clk);
  endtask

  // Size word first, then the flits
  task automatic write_packet(input logic [31:0] adr, input int size);
    logic [31:0] rdata;
    logic        err;
    bus_access(1'b1, adr, 32'(size), rdata, err);
    expect_equal("wbs_err_o", 32'(err), 32'h0);
    for (int k = 0; k < size; k++) begin
      pay_state = lcg_next(pay_state);
      tx_exp_flit[tx_wr] = pay_state;
      tx_exp_last[tx_wr] = (k == size - 1);
      tx_wr++;
      bus_access(1'b1, adr, pay_state, rdata, err);
      expect_equal("wbs_err_o", 32'(err), 32'h0);
    end
  endtask

  task automatic send_packet(input logic [2:0] cls, input int size);
    logic [31:0] flit;
    int          t;
    for (int k = 0; k < size; k++) begin
      pay_state = lcg_next(pay_state);
      flit = pay_state;
      // Head flit carries the class
      if (k == 0) begin
        flit[CLASS_LSB +: CLASS_WIDTH] = cls;
      end
      if (cls == CLASS_MSG) begin
        rx_exp[rx_wr] = flit;
        rx_wr++;
      end
      noc_in_flit_i  <= flit;
      noc_in_last_i  <= (k == size - 1);
      noc_in_valid_i <= 1'b1;
      t = 0;
      @(negedge clk);
      while (!noc_in_ready_o) begin
        if (t == TIMEOUT) begin
          timeout_fail("noc_in_ready_o for an input flit");
        end
        t++;
        @(negedge clk);
      end
      @(posedge clk);
    end
    noc_in_valid_i <= 1'b0;
    noc_in_last_i  <= 1'b0;
  endtask

  task automatic check_output();
    int t;
    t = 0;
    @(negedge clk);
    while (rcv_cnt < tx_wr) begin
      if (t == TIMEOUT) begin
        timeout_fail("complete packet on noc_out");
      end
      t++;
      @(negedge clk);
    end
    // Last transfer is done by now and the port must be idle
    @(negedge clk);
    expect_equal("noc_out_valid_o", 32'(noc_out_valid_o), 32'h0);
    expect_equal("noc_out flit count", rcv_cnt, tx_wr);
    while (tx_chk < tx_wr) begin
      expect_equal("noc_out_flit_o", out_flit[tx_chk], tx_exp_flit[tx_chk]);
      expect_equal("noc_out_last_o", 32'(out_last[tx_chk]), 32'(tx_exp_last[tx_chk]));
      tx_chk++;
    end
  endtask

  task automatic wait_irq();
    int t;
    t = 0;
    @(negedge clk);
    while (!irq_o) begin
      if (t == TIMEOUT) begin
        timeout_fail("rise of irq_o");
      end
      t++;
      @(negedge clk);
    end
  endtask

  ////////////////////////////////////////
  // Network output side
  ////////////////////////////////////////

  initial begin
    noc_out_ready_i = 1'b0;
    forever begin
      @(posedge clk);
      ready_state = lcg_next(ready_state);
      noc_out_ready_i <= ready_state[31];
    end
  end

  // Valid and ready both high here means a transfer at the next edge
  always @(negedge clk) begin
    if (!rst_i && noc_out_valid_o && noc_out_ready_i && rcv_cnt < MAX_FLITS) begin
      out_flit[rcv_cnt] = noc_out_flit_o;
      out_last[rcv_cnt] = noc_out_last_o;
      rcv_cnt++;
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    logic [31:0] arg;
    logic [31:0] rdata;
    logic        err;
    rst_i          = 1'b1;
    noc_in_flit_i  = '0;
    noc_in_last_i  = 1'b0;
    noc_in_valid_i = 1'b0;
    wbs_adr_i      = '0;
    wbs_dat_i      = '0;
    wbs_cyc_i      = 1'b0;
    wbs_stb_i      = 1'b0;
    wbs_we_i       = 1'b0;
    repeat (10) @(posedge clk);
    rst_i <= 1'b0;
    @(negedge clk);
    expect_equal("noc_out_valid_o", 32'(noc_out_valid_o), 32'h0);
    expect_equal("wbs_ack_o", 32'(wbs_ack_o), 32'h0);
    expect_equal("wbs_err_o", 32'(wbs_err_o), 32'h0);
    expect_equal("irq_o", 32'(irq_o), 32'h0);
    expect_equal("noc_in_ready_o", 32'(noc_in_ready_o), 32'h0);
    // Input ready comes up one cycle after reset is released
    @(negedge clk);
    expect_equal("noc_in_ready_o", 32'(noc_in_ready_o), 32'h1);

    for (int r = 0; r < NSTEPS; r++) begin
      @(posedge clk);
      arg = STEPS[r].arg;
      case (STEPS[r].op)
        OP_BUS_READ: begin
          if (STEPS[r].size > 0) begin
            wait_irq();
            @(posedge clk);
          end
          bus_access(1'b0, arg, 32'h0, rdata, err);
          // Regions above 1 are unmapped
          expect_equal("wbs_err_o", 32'(err), 32'(arg[REGION_LSB +: 4] > 4'd1));
          if (!err) begin
            expect_equal("wbs_dat_o", rdata, STEPS[r].expected);
          end
          for (int k = 0; k < STEPS[r].size; k++) begin
            bus_access(1'b0, arg, 32'h0, rdata, err);
            expect_equal("wbs_dat_o", rdata, rx_exp[rx_rd]);
            rx_rd++;
          end
          if (STEPS[r].size > 0) begin
            @(negedge clk);
            expect_equal("irq_o", 32'(irq_o), 32'h0);
          end
        end
        OP_BUS_WRITE: write_packet(arg, STEPS[r].size);
        OP_NET_SEND: send_packet(arg[2:0], STEPS[r].size);
        OP_NET_EXPECT: check_output();
      endcase
    end

    $display("all tests passed");
    $finish;
  end

endmodule

/* network_adapter.f */
na_pkg.sv
noc_buffer.sv
na_wb_decode.sv
na_conf.sv
mp_simple_rx.sv
mp_simple_tx.sv
network_adapter.sv
network_adapter_asserts.sv
network_adapter_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the network adapter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module network_adapter_tb \
  -f network_adapter.f \
  -o vsim_network_adapter
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/vsim_network_adapter > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^all tests passed$" "$LOG"; then
  echo "RESULT: PASS"
  exit 0
else
  echo "RESULT: FAIL"
  exit 1
fi
